// ==== Bender.yml ====
package:
  name: opl3_audio

sources:
  - target: any(rtl, test)
    include_dirs:
      - src
    files:
      - src/opl3_pkg.sv
      - src/synchronizer.sv
      - src/channel_mixer.sv
      - src/dac_prep.sv
      - src/opl3_audio_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - bench/opl3_audio_checker.sv
      - bench/opl3_audio_tb.sv

// ==== bench/opl3_audio_checker.sv ====
//########################################
// strobe checks for the audio path. one
// instance is bound into the mixer on clk
// and one into dac_prep on clk_host.
// failures show up as assertion errors.
//########################################

module opl3_audio_checker #(
    parameter int settle_cycles = 2 // edges until reset has cleared the strobe.
) (
    input logic clk,    // clock of the watched strobe.
    input logic reset,  // clk domain reset of the path.
    input logic strobe  // one cycle pulse under test.
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned error_count = 0; // read by the testbench.

    // a strobe marks one sample, so it never stays high.
    a_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        strobe |=> !strobe
    ) else begin
        error_count++;
        $error("strobe high for two cycles in a row");
    end

    // host side needs a few edges before the synchronized reset lands.
    a_low_in_reset: assert property (
        @(posedge clk)
        reset [*settle_cycles] |-> !strobe
    ) else begin
        error_count++;
        $error("strobe high while reset is applied");
    end

endmodule

bind channel_mixer opl3_audio_checker #(.settle_cycles(2)) u_mixer_checker (
    .clk    (clk),
    .reset  (reset),
    .strobe (channel_valid)
);

bind dac_prep opl3_audio_checker #(.settle_cycles(4)) u_dac_checker (
    .clk    (clk_host),
    .reset  (reset),
    .strobe (sample_valid)
);

// ==== bench/opl3_audio_tb.sv ====
//########################################
// testbench for the audio output path.
// drives lfsr channel results in periods
// of random length, models the mix, clamp
// and dac shift, and checks each sample
// that comes out in the host domain.
//########################################

`include "opl3_settings.svh"

module opl3_audio_tb
    import opl3_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int kind_random  = 0;
    localparam int kind_empty   = 1; // no channel input at all.
    localparam int kind_sat_pos = 2;
    localparam int kind_sat_neg = 3;
    localparam int kind_late    = 4; // single input in the sample_end cycle.

    localparam int num_directed = 6;
    localparam int num_random   = 200;
    localparam int num_periods  = num_directed + num_random;
    localparam int watchdog_ns  = 2 * num_periods * 24 * 100; // 24 cycles max per period.

    localparam int sample_max = (1 << (`SAMPLE_WIDTH - 1)) - 1;
    localparam int sample_min = -(1 << (`SAMPLE_WIDTH - 1));

    logic        clk = 1'b0;
    logic        clk_host = 1'b0;
    logic        reset;
    logic        channel_in_valid;
    channel_in_t channel_in;
    logic        sample_end;
    logic        sample_valid;
    dac_stereo_t sample;

    logic [31:0] lfsr_state = 32'hc10667e9;
    dac_stereo_t expected_q[$]; // one entry per closed period.
    int          model_l = 0;   // running sums of the model.
    int          model_r = 0;
    int          end_count = 0; // sample_end strobes seen at the dut input.
    int          out_count = 0;
    logic        monitor_on = 1'b0;

    always #50 clk = ~clk;
    always #18.5 clk_host = ~clk_host; // faster than clk and not a multiple of it.

    opl3_audio_top i_dut (
        .clk              (clk),
        .clk_host         (clk_host),
        .reset            (reset),
        .channel_in_valid (channel_in_valid),
        .channel_in       (channel_in),
        .sample_end       (sample_end),
        .sample_valid     (sample_valid),
        .sample           (sample)
    );

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic int clamp_to_sample(input int value);
        if (value > sample_max)
            return sample_max;
        else if (value < sample_min)
            return sample_min;
        return value;
    endfunction

    // clamp and then multiply up to dac full scale.
    function automatic dac_stereo_t scale_pair(input int sum_l, input int sum_r);
        dac_stereo_t pair;
        pair.l = dac_sample_t'(clamp_to_sample(sum_l) * (1 << `DAC_LEFT_SHIFT));
        pair.r = dac_sample_t'(clamp_to_sample(sum_r) * (1 << `DAC_LEFT_SHIFT));
        return pair;
    endfunction

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_dac_sample(input string name, input dac_sample_t actual,
                                    input dac_sample_t expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            fail_run();
        end
    endtask

    task automatic check_stereo(input dac_stereo_t actual, input dac_stereo_t expected);
        check_dac_sample("sample.l", actual.l, expected.l);
        check_dac_sample("sample.r", actual.r, expected.r);
    endtask

    // drives one clk cycle and updates the model with what was driven.
    task automatic drive_cycle(input logic valid, input sample_t value, input logic pan_l,
                               input logic pan_r, input logic last);
        @(posedge clk);
        channel_in_valid <= valid;
        channel_in       <= '{sample: value, pan_l: pan_l, pan_r: pan_r};
        sample_end       <= last;
        if (valid && pan_l)
            model_l = model_l + int'(value);
        if (valid && pan_r)
            model_r = model_r + int'(value);
        if (last) begin
            expected_q.push_back(scale_pair(model_l, model_r)); // input in this cycle counts.
            model_l = 0;
            model_r = 0;
        end
    endtask

    // a period of 4 to 24 cycles whose last cycle carries sample_end.
    task automatic run_period(input int kind);
        int          len;
        logic        valid;
        logic        pan_l;
        logic        pan_r;
        sample_t     value;
        logic [31:0] bits;
        len = 4 + int'(random_bits(5)) % 21;
        for (int c = 0; c < len; c++) begin
            bits = random_bits(14);
            case (kind)
                kind_empty: begin
                    valid = 1'b0;
                    pan_l = 1'b0;
                    pan_r = 1'b0;
                    value = '0;
                end
                kind_sat_pos: begin
                    valid = 1'b1;
                    pan_l = 1'b1;
                    pan_r = 1'b1;
                    value = sample_t'({2'b01, bits[13:0]}); // at least half scale.
                end
                kind_sat_neg: begin
                    valid = 1'b1;
                    pan_l = 1'b1;
                    pan_r = 1'b1;
                    value = sample_t'({2'b10, bits[13:0]});
                end
                kind_late: begin
                    valid = (c == len - 1);
                    pan_l = 1'b1;
                    pan_r = 1'b1;
                    value = sample_t'(random_bits(16));
                end
                default: begin
                    valid = bits[13];
                    pan_l = bits[12];
                    pan_r = bits[11];
                    value = sample_t'(random_bits(16));
                end
            endcase
            drive_cycle(valid, value, pan_l, pan_r, c == len - 1);
        end
    endtask

    // counts the period ends that actually reach the dut.
    always @(negedge clk) begin
        if (sample_end === 1'b1)
            end_count++;
    end

    // outputs are sampled mid host cycle where they are stable.
    always @(negedge clk_host) begin
        if (monitor_on) begin
            if (sample_valid !== 1'b0 && sample_valid !== 1'b1) begin
                $display("sample_valid is unknown after reset");
                fail_run();
            end else if (sample_valid) begin
                if (expected_q.size() == 0) begin
                    $display("sample_valid pulsed with no sample pending");
                    fail_run();
                end else begin
                    check_stereo(sample, expected_q.pop_front());
                    out_count++;
                end
            end
        end
    end

    // the bound strobe assertions count their failures.
    always @(negedge clk_host) begin
        if (i_dut.u_channel_mixer.u_mixer_checker.error_count != 0 ||
            i_dut.u_dac_prep.u_dac_checker.error_count != 0) begin
            $display("a strobe assertion in the bound checker failed");
            fail_run();
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before all samples came out");
        fail_run();
    end

    initial begin
        logic [31:0] pick;
        reset            = 1'b1;
        channel_in_valid = 1'b0;
        channel_in       = '0;
        sample_end       = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        monitor_on = 1'b1;
        // nothing may come out before the first sample_end.
        repeat (10) begin
            @(negedge clk);
            if (sample_valid !== 1'b0) begin
                $display("sample_valid rose before any sample_end");
                fail_run();
            end
        end
        run_period(kind_random);
        run_period(kind_empty);
        run_period(kind_sat_pos);
        run_period(kind_sat_neg);
        run_period(kind_late);
        run_period(kind_empty); // must stay zero after the late input.
        for (int p = 0; p < num_random; p++) begin
            pick = random_bits(3);
            case (pick[2:0])
                3'd4:    run_period(kind_empty);
                3'd5:    run_period(kind_sat_pos);
                3'd6:    run_period(kind_sat_neg);
                3'd7:    run_period(kind_late);
                default: run_period(kind_random);
            endcase
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0); // release sample_end.
        while (out_count < end_count)
            @(posedge clk);
        repeat (8) @(posedge clk); // room for a stray extra pulse.
        if (expected_q.size() == 0 && out_count == end_count) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("got %0d samples for %0d sample_end strobes", out_count, end_count);
            fail_run();
        end
    end

endmodule

// ==== opl3_audio.f ====
+incdir+src
src/opl3_pkg.sv
src/synchronizer.sv
src/channel_mixer.sv
src/dac_prep.sv
src/opl3_audio_top.sv
bench/opl3_audio_checker.sv
bench/opl3_audio_tb.sv

// ==== src/channel_mixer.sv ====
//########################################
// sums panned channel results over one
// sample period. at sample_end the sums
// are clamped to sample width, held on
// channel and flagged by channel_valid
// one cycle later.
//########################################

`include "opl3_settings.svh"

module channel_mixer
    import opl3_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           channel_in_valid, // one cycle strobe with channel_in.
    input  channel_in_t    channel_in,
    input  logic           sample_end,       // closes the current period.
    output logic           channel_valid,    // one cycle pulse per period.
    output stereo_sample_t channel           // held until the next pulse.
);

    // clamp limits of sample_t held in accumulator width.
    localparam acc_t sat_max = acc_t'(2 ** (`SAMPLE_WIDTH - 1) - 1);
    localparam acc_t sat_min = -acc_t'(2 ** (`SAMPLE_WIDTH - 1));

    acc_t acc_l; // running left sum.
    acc_t acc_r; // running right sum.

    acc_t add_l; // contribution of this cycle to the left side.
    acc_t add_r;
    acc_t sum_l; // sum including this cycle.
    acc_t sum_r;

    sample_t sat_l; // clamped sums, only used on sample_end.
    sample_t sat_r;

    // clamp an accumulator value into sample range.
    function automatic sample_t saturate(input acc_t value);
        sample_t result;
        if (value > sat_max)
            result = sample_t'(sat_max);
        else if (value < sat_min)
            result = sample_t'(sat_min);
        else
            result = value[`SAMPLE_WIDTH-1:0]; // fits, drop the guard bits.
        return result;
    endfunction

    // a result only counts on the sides its pan bits select.
    always_comb begin
        add_l = '0;
        add_r = '0;
        if (channel_in_valid && channel_in.pan_l)
            add_l = acc_t'(channel_in.sample); // sign extended.
        if (channel_in_valid && channel_in.pan_r)
            add_r = acc_t'(channel_in.sample);
    end

    // an input arriving with sample_end still belongs to the closing period.
    assign sum_l = acc_l + add_l;
    assign sum_r = acc_r + add_r;

    assign sat_l = saturate(sum_l);
    assign sat_r = saturate(sum_r);

    // accumulate, or close the period and restart from zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_l <= '0;
            acc_r <= '0;
        end else if (sample_end) begin
            acc_l <= '0; // next period starts empty.
            acc_r <= '0;
        end else begin
            acc_l <= sum_l;
            acc_r <= sum_r;
        end
    end

    // strobe follows sample_end by one cycle.
    always_ff @(posedge clk) begin
        if (reset)
            channel_valid <= 1'b0;
        else
            channel_valid <= sample_end;
    end

    // held pair, only updated in the cycle of the pulse.
    always_ff @(posedge clk) begin
        if (reset) begin
            channel.l <= '0;
            channel.r <= '0;
        end else if (sample_end) begin
            channel.l <= sat_l;
            channel.r <= sat_r;
        end
    end

endmodule

// ==== src/dac_prep.sv ====
//########################################
// widens the mixed pair to dac width and,
// when host sync is on, moves it into the
// clk_host domain. only the strobe crosses
// through flops; the pair is held for a
// whole sample period and latched there.
//########################################

`include "opl3_settings.svh"

module dac_prep
    import opl3_pkg::*;
(
    input  logic           clk,
    input  logic           clk_host,      // must be faster than clk.
    input  logic           reset,         // clk domain reset.
    input  logic           channel_valid, // one clk pulse per sample.
    input  stereo_sample_t channel,       // held pair from the mixer.
    output logic           sample_valid,  // one cycle pulse per sample.
    output dac_stereo_t    sample         // held between pulses.
);

    logic        valid_p1; // registered strobe, clk domain.
    dac_stereo_t pair_p1;  // widened pair, clk domain.

    // sign extend first, then shift up to dac full scale.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_p1 <= 1'b0;
            pair_p1  <= '0;
        end else begin
            valid_p1  <= channel_valid;
            pair_p1.l <= dac_sample_t'(channel.l) <<< `DAC_LEFT_SHIFT;
            pair_p1.r <= dac_sample_t'(channel.r) <<< `DAC_LEFT_SHIFT;
        end
    end

    if (`OPL3_SYNC_TO_HOST) begin : g_host_sync
        logic reset_host; // reset as seen in clk_host.
        logic valid_sync; // strobe after two host flops.
        logic valid_sync_d;

        // reset path has no reset of its own.
        synchronizer reset_sync (
            .clk   (clk_host),
            .reset (1'b0),
            .in    (reset),
            .out   (reset_host)
        );

        synchronizer valid_sync_inst (
            .clk   (clk_host),
            .reset (reset_host),
            .in    (valid_p1),
            .out   (valid_sync)
        );

        // pair_p1 is stable while the strobe is high, so copy it then.
        always_ff @(posedge clk_host) begin
            if (reset_host) begin
                valid_sync_d <= 1'b0;
                sample_valid <= 1'b0;
                sample       <= '0;
            end else begin
                valid_sync_d <= valid_sync;
                sample_valid <= valid_sync && !valid_sync_d; // rising edge only.
                if (valid_sync)
                    sample <= pair_p1;
            end
        end
    end else begin : g_direct
        // same clock as the mixer, registers go straight out.
        assign sample_valid = valid_p1;
        assign sample       = pair_p1;
    end

endmodule

// ==== src/opl3_audio_top.sv ====
//########################################
// audio output path of the synth core.
// takes channel results from the operator
// pipeline, mixes them per sample period
// and hands dac width stereo samples to
// the host clock domain.
//########################################

module opl3_audio_top
    import opl3_pkg::*;
(
    input  logic        clk,              // synth clock.
    input  logic        clk_host,         // host clock, faster than clk.
    input  logic        reset,            // synchronous to clk.
    input  logic        channel_in_valid, // one cycle strobe per channel result.
    input  channel_in_t channel_in,       // result with pan enables.
    input  logic        sample_end,       // one cycle strobe, closes the period.
    output logic        sample_valid,     // one host cycle pulse per sample.
    output dac_stereo_t sample            // held between pulses.
);

    logic           channel_valid; // mixer strobe, clk domain.
    stereo_sample_t channel;       // mixed and clamped pair.

    // sums panned results and clamps at the end of each period.
    channel_mixer u_channel_mixer (
        .clk              (clk),
        .reset            (reset),
        .channel_in_valid (channel_in_valid),
        .channel_in       (channel_in),
        .sample_end       (sample_end),
        .channel_valid    (channel_valid),
        .channel          (channel)
    );

    // widens the pair and crosses it to the host.
    dac_prep u_dac_prep (
        .clk           (clk),
        .clk_host      (clk_host),
        .reset         (reset),
        .channel_valid (channel_valid),
        .channel       (channel),
        .sample_valid  (sample_valid),
        .sample        (sample)
    );

endmodule

// ==== src/opl3_pkg.sv ====
//########################################
// types for the audio output path.
// import with a wildcard in the module
// header; widths come from the settings.
//########################################

package opl3_pkg;

`include "opl3_settings.svh"

    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t; // one audio sample.

    // running sum in the mixer, wider than a sample.
    typedef logic signed [`SAMPLE_WIDTH+`ACC_GUARD_BITS-1:0] acc_t;

    typedef logic signed [`DAC_OUTPUT_WIDTH-1:0] dac_sample_t; // one dac sample.

    // one result from the operator pipeline with its pan enables.
    typedef struct packed {
        sample_t sample;
        logic    pan_l; // add into the left sum.
        logic    pan_r; // add into the right sum.
    } channel_in_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_sample_t;

    // pair after widening to the dac.
    typedef struct packed {
        dac_sample_t l;
        dac_sample_t r;
    } dac_stereo_t;

endpackage

// ==== src/opl3_settings.svh ====
//########################################
// widths and build switches shared by the
// audio output path. the package pulls this
// in for its types; rtl files include it
// where they need a value directly.
//########################################

`ifndef OPL3_SETTINGS_SVH
`define OPL3_SETTINGS_SVH

// one channel result and one mixed sample.
`define SAMPLE_WIDTH 16

// sample width seen by the dac.
`define DAC_OUTPUT_WIDTH 24

// left shift that widens a sample to dac width.
`define DAC_LEFT_SHIFT 8

`define ACC_GUARD_BITS 5 // headroom so 18+ full scale channels never wrap.

// 1 adds the crossing into clk_host inside dac_prep, 0 drives the outputs from clk.
`define OPL3_SYNC_TO_HOST 1

`endif

// ==== src/synchronizer.sv ====
//########################################
// two flop synchronizer for one bit.
// both flops run on the destination clock
// and clear on its synchronous reset.
//########################################

module synchronizer (
    input  logic clk,   // destination clock.
    input  logic reset, // destination domain reset.
    input  logic in,    // bit from the source domain.
    output logic out    // bit after two destination flops.
);

    logic meta; // first stage, may go metastable.

    // sample the foreign bit, then give it a full cycle to settle.
    always_ff @(posedge clk) begin
        if (reset) begin
            meta <= 1'b0;
            out  <= 1'b0;
        end else begin
            meta <= in;
            out  <= meta; // settled copy.
        end
    end

endmodule
